// ==== Bender.yml ====
package:
  name: lc3b_alu_pipe

sources:
  - include_dirs:
      - .
    files:
      - lc3b_types_pkg.sv
      - pipe_pkg.sv
      - stream_fifo.sv
      - regfile.sv
      - decode.sv
      - execute.sv
      - lc3b_alu_pipe.sv
  - target: test
    include_dirs:
      - .
    files:
      - lc3b_alu_pipe_chk.sv
      - lc3b_alu_pipe_tb.sv

// ==== decode.sv ====
`timescale 1ns/10ps
`default_nettype none

module decode import lc3b_types_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  logic      in_valid,
	output logic      in_ready,
	input  lc3b_word  in_pc,
	input  lc3b_word  in_inst,
	input  logic      wb_en,
	input  lc3b_reg   wb_dest,
	input  lc3b_word  wb_value,
	input  lc3b_word  fwd_value,
	output logic      ex_valid,
	output lc3b_word  ex_pc,
	output lc3b_word  ex_inst,
	output lc3b_reg   ex_dest,
	output lc3b_word  ex_a,
	output lc3b_word  ex_b,
	output lc3b_aluop ex_aluop,
	output logic      ex_writes,
	input  logic      ex_ready
);

	lc3b_opcode opcode;
	lc3b_reg    src_a;
	lc3b_reg    src_b;
	lc3b_word   reg_a;
	lc3b_word   reg_b;
	lc3b_word   opnd_a;
	lc3b_word   opnd_b;
	lc3b_word   imm5;
	lc3b_aluop  aluop;
	logic       writes;
	logic       use_imm;

	assign opcode = lc3b_opcode'(in_inst[15:12]);
	assign src_a  = in_inst[8:6];
	assign src_b  = in_inst[2:0];
	assign imm5   = {{11{in_inst[4]}}, in_inst[4:0]};

	regfile u_regfile (
		.clk      (clk),
		.rst      (rst),
		.load     (wb_en),
		.dest     (wb_dest),
		.in_value (wb_value),
		.src_a    (src_a),
		.src_b    (src_b),
		.reg_a    (reg_a),
		.reg_b    (reg_b)
	);

	// the instruction in the stage register only writes back when it leaves,
	// which is exactly when a new one is loaded, so its result is taken here.
	always_comb begin
		opnd_a = reg_a;
		opnd_b = reg_b;
		if (ex_valid && ex_writes && ex_dest == src_a) begin
			opnd_a = fwd_value;
		end
		if (ex_valid && ex_writes && ex_dest == src_b) begin
			opnd_b = fwd_value;
		end
	end

	always_comb begin
		aluop   = alu_pass;
		writes  = 1'b0;
		use_imm = 1'b0;
		case (opcode)
			op_add: begin
				aluop   = alu_add;
				writes  = 1'b1;
				use_imm = in_inst[5];
			end
			op_and: begin
				aluop   = alu_and;
				writes  = 1'b1;
				use_imm = in_inst[5];
			end
			op_not: begin
				aluop  = alu_not;
				writes = 1'b1;
			end
			default: ;
		endcase
	end

	assign in_ready = !ex_valid || ex_ready;

	always_ff @(posedge clk) begin
		if (rst) begin
			ex_valid <= 1'b0;
		end else if (in_ready) begin
			ex_valid <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (in_ready && in_valid) begin
			ex_pc     <= in_pc;
			ex_inst   <= in_inst;
			ex_dest   <= in_inst[11:9];
			ex_a      <= opnd_a;
			ex_b      <= use_imm ? imm5 : opnd_b;
			ex_aluop  <= aluop;
			ex_writes <= writes;
		end
	end

endmodule

`default_nettype wire

// ==== execute.sv ====
`timescale 1ns/10ps
`default_nettype none

module execute
	import lc3b_types_pkg::*;
	import pipe_pkg::*;
(
	input  logic        ex_valid,
	input  lc3b_word    ex_pc,
	input  lc3b_reg     ex_dest,
	input  lc3b_word    ex_a,
	input  lc3b_word    ex_b,
	input  lc3b_aluop   ex_aluop,
	input  logic        ex_writes,
	output logic        ex_ready,
	input  logic        clk,
	input  logic        rst,
	output logic        ret_valid,
	input  logic        ret_ready,
	output retire_entry ret_data,
	output logic        wb_en,
	output lc3b_reg     wb_dest,
	output lc3b_word    wb_value,
	output lc3b_word    fwd_value
);

	lc3b_word alu_out;
	lc3b_cc   new_cc;
	lc3b_cc   cc_q;
	logic     xfer;

	always_comb begin
		case (ex_aluop)
			alu_add: alu_out = ex_a + ex_b;
			alu_and: alu_out = ex_a & ex_b;
			alu_not: alu_out = ~ex_a;
			default: alu_out = ex_a;
		endcase
	end

	always_comb begin
		if (alu_out[15]) begin
			new_cc = 3'b100;
		end else if (alu_out == '0) begin
			new_cc = 3'b010;
		end else begin
			new_cc = 3'b001;
		end
	end

	assign ret_valid = ex_valid;
	assign ex_ready  = ret_ready;
	assign xfer      = ex_valid && ret_ready;

	assign wb_en     = xfer && ex_writes;
	assign wb_dest   = ex_dest;
	assign wb_value  = alu_out;
	assign fwd_value = alu_out;

	assign ret_data.pc    = ex_pc;
	assign ret_data.dest  = ex_dest;
	assign ret_data.value = alu_out;
	assign ret_data.wrote = ex_writes;
	assign ret_data.cc    = ex_writes ? new_cc : cc_q;

	// the code starts at z, as if the last result had been zero.
	always_ff @(posedge clk) begin
		if (rst) begin
			cc_q <= 3'b010;
		end else if (wb_en) begin
			cc_q <= new_cc;
		end
	end

endmodule

`default_nettype wire

// ==== lc3b_alu_pipe.f ====
+incdir+.
lc3b_types_pkg.sv
pipe_pkg.sv
stream_fifo.sv
regfile.sv
decode.sv
execute.sv
lc3b_alu_pipe.sv
lc3b_alu_pipe_chk.sv
lc3b_alu_pipe_tb.sv

// ==== lc3b_alu_pipe.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "lc3b_params.svh"

module lc3b_alu_pipe
	import lc3b_types_pkg::*;
	import pipe_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  logic     inst_valid,
	output logic     inst_ready,
	input  lc3b_word inst_pc,
	input  lc3b_word inst_data,
	output logic     ret_valid,
	input  logic     ret_ready,
	output lc3b_word ret_pc,
	output lc3b_reg  ret_dest,
	output lc3b_word ret_value,
	output logic     ret_wrote,
	output lc3b_cc   ret_cc
);

	inst_entry   in_entry;
	inst_entry   dec_entry;
	logic        dec_valid;
	logic        dec_ready;
	logic        ex_valid;
	lc3b_word    ex_pc;
	lc3b_reg     ex_dest;
	lc3b_word    ex_a;
	lc3b_word    ex_b;
	lc3b_aluop   ex_aluop;
	logic        ex_writes;
	logic        ex_ready;
	logic        wb_en;
	lc3b_reg     wb_dest;
	lc3b_word    wb_value;
	lc3b_word    fwd_value;
	logic        push_valid;
	logic        push_ready;
	retire_entry push_entry;
	retire_entry ret_entry;

	assign in_entry.pc   = inst_pc;
	assign in_entry.inst = inst_data;

	stream_fifo #(.payload_t(inst_entry), .DEPTH(`IN_FIFO_DEPTH)) in_queue (
		.clk(clk), .rst(rst),
		.in_valid(inst_valid), .in_ready(inst_ready), .in_data(in_entry),
		.out_valid(dec_valid), .out_ready(dec_ready), .out_data(dec_entry)
	);

	decode u_decode (
		.clk(clk), .rst(rst),
		.in_valid(dec_valid), .in_ready(dec_ready),
		.in_pc(dec_entry.pc), .in_inst(dec_entry.inst),
		.wb_en(wb_en), .wb_dest(wb_dest), .wb_value(wb_value), .fwd_value(fwd_value),
		.ex_valid(ex_valid), .ex_pc(ex_pc), .ex_inst(), .ex_dest(ex_dest),
		.ex_a(ex_a), .ex_b(ex_b), .ex_aluop(ex_aluop), .ex_writes(ex_writes),
		.ex_ready(ex_ready)
	);

	execute u_execute (
		.ex_valid(ex_valid), .ex_pc(ex_pc), .ex_dest(ex_dest), .ex_a(ex_a), .ex_b(ex_b),
		.ex_aluop(ex_aluop), .ex_writes(ex_writes), .ex_ready(ex_ready),
		.clk(clk), .rst(rst),
		.ret_valid(push_valid), .ret_ready(push_ready), .ret_data(push_entry),
		.wb_en(wb_en), .wb_dest(wb_dest), .wb_value(wb_value), .fwd_value(fwd_value)
	);

	stream_fifo #(.payload_t(retire_entry), .DEPTH(`RET_FIFO_DEPTH)) ret_queue (
		.clk(clk), .rst(rst),
		.in_valid(push_valid), .in_ready(push_ready), .in_data(push_entry),
		.out_valid(ret_valid), .out_ready(ret_ready), .out_data(ret_entry)
	);

	assign ret_pc    = ret_entry.pc;
	assign ret_dest  = ret_entry.dest;
	assign ret_value = ret_entry.value;
	assign ret_wrote = ret_entry.wrote;
	assign ret_cc    = ret_entry.cc;

endmodule

`default_nettype wire

// ==== lc3b_alu_pipe_chk.sv ====
`timescale 1ns/10ps
`default_nettype none

module lc3b_alu_pipe_chk import lc3b_types_pkg::*; (
	input logic     clk,
	input logic     rst,
	input logic     ret_valid,
	input logic     ret_ready,
	input lc3b_word ret_pc,
	input lc3b_reg  ret_dest,
	input lc3b_word ret_value,
	input logic     ret_wrote,
	input lc3b_cc   ret_cc
);

	int assert_fails = 0;

	// nothing can reach the output port in the cycle after a reset edge.
	ret_low_in_reset: assert property (@(posedge clk) rst |=> !ret_valid)
		else begin
			assert_fails++;
			$error("ret_valid rose directly after a reset cycle");
		end

	// an offered record may not change or vanish until it is taken.
	ret_held_when_stalled: assert property (@(posedge clk) disable iff (rst)
		ret_valid && !ret_ready |=> ret_valid && $stable(ret_pc) && $stable(ret_dest)
			&& $stable(ret_value) && $stable(ret_wrote) && $stable(ret_cc))
		else begin
			assert_fails++;
			$error("retire record changed while ret_ready was low");
		end

	// exactly one of n, z and p is set on every offered record.
	ret_cc_onehot: assert property (@(posedge clk) disable iff (rst)
		ret_valid |-> $onehot(ret_cc))
		else begin
			assert_fails++;
			$error("ret_cc is not one-hot");
		end

endmodule

bind lc3b_alu_pipe lc3b_alu_pipe_chk chk (.*);

`default_nettype wire

// ==== lc3b_alu_pipe_tb.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "lc3b_params.svh"

module lc3b_alu_pipe_tb
	import lc3b_types_pkg::*;
	import pipe_pkg::*;
();

	localparam int NUM_INSTS   = 400;
	localparam int STALL_LIMIT = 200;
	localparam int RUN_LIMIT   = 20000;
	localparam int DRAIN_LIMIT = 2000;

	logic     clk;
	logic     rst;
	logic     inst_valid;
	logic     inst_ready;
	lc3b_word inst_pc;
	lc3b_word inst_data;
	logic     ret_valid;
	logic     ret_ready;
	lc3b_word ret_pc;
	lc3b_reg  ret_dest;
	lc3b_word ret_value;
	logic     ret_wrote;
	lc3b_cc   ret_cc;

	integer      seed;
	int          mismatches;
	int          protocol_errs;
	int          timeouts;
	int          sent;
	int          retired;
	int          cycles;
	int          stall;
	int          waited;
	lc3b_word    next_pc;
	lc3b_word    model_regs [8];
	lc3b_cc      model_cc;
	retire_entry exp_q [$];

	always #10 clk = ~clk;

	lc3b_alu_pipe dut (
		.clk(clk), .rst(rst),
		.inst_valid(inst_valid), .inst_ready(inst_ready), .inst_pc(inst_pc), .inst_data(inst_data),
		.ret_valid(ret_valid), .ret_ready(ret_ready), .ret_pc(ret_pc), .ret_dest(ret_dest),
		.ret_value(ret_value), .ret_wrote(ret_wrote), .ret_cc(ret_cc)
	);

	// most picks are ADD, AND or NOT, the rest is any opcode at all.
	function automatic lc3b_word random_inst();
		logic [31:0] r;
		logic [3:0]  op;
		r = $random(seed);
		if (r[3:0] < 4'd5) begin
			op = 4'b0001;
		end else if (r[3:0] < 4'd10) begin
			op = 4'b0101;
		end else if (r[3:0] < 4'd13) begin
			op = 4'b1001;
		end else begin
			op = r[31:28];
		end
		if (op == 4'b1001) begin
			return {op, r[15:10], 6'h3f};
		end
		return {op, r[15:4]};
	endfunction

	// ISA semantics of one instruction, in program order.
	task automatic apply_model(input lc3b_word pc, input lc3b_word inst);
		lc3b_word    src2;
		lc3b_word    result;
		logic        writes;
		retire_entry e;
		src2   = inst[5] ? {{11{inst[4]}}, inst[4:0]} : model_regs[inst[2:0]];
		result = '0;
		writes = 1'b1;
		case (inst[15:12])
			4'b0001: result = model_regs[inst[8:6]] + src2;
			4'b0101: result = model_regs[inst[8:6]] & src2;
			4'b1001: result = ~model_regs[inst[8:6]];
			default: writes = 1'b0;
		endcase
		if (writes) begin
			model_regs[inst[11:9]] = result;
			model_cc = result[15] ? 3'b100 : ((result == '0) ? 3'b010 : 3'b001);
		end
		e.pc    = pc;
		e.dest  = inst[11:9];
		e.value = result;
		e.wrote = writes;
		e.cc    = model_cc;
		exp_q.push_back(e);
	endtask

	task automatic compare_field(input string name, input logic [15:0] got, input logic [15:0] want);
		assert (got === want) else begin
			mismatches++;
			$display("CHECK FAILED: %s got 0x%h expected 0x%h at %0t", name, got, want, $time);
		end
	endtask

	task automatic check_retire();
		retire_entry e;
		assert (exp_q.size() != 0) else begin
			protocol_errs++;
			$display("a record retired with no instruction outstanding at %0t", $time);
		end
		if (exp_q.size() != 0) begin
			e = exp_q.pop_front();
			compare_field("ret_pc", ret_pc, e.pc);
			compare_field("ret_dest", ret_dest, e.dest);
			if (e.wrote) begin
				compare_field("ret_value", ret_value, e.value);
			end
			compare_field("ret_wrote", ret_wrote, e.wrote);
			compare_field("ret_cc", ret_cc, e.cc);
			retired++;
		end
	endtask

	// samples the settled values at the edge, then drives the next ones.
	// a full input queue implies a held stage and a retire queue at most one short of full.
	task automatic step_cycle();
		logic [31:0] r;
		@(posedge clk);
		r = $random(seed);
		assert (inst_ready || (sent - retired) >= `IN_FIFO_DEPTH + `RET_FIFO_DEPTH) else begin
			mismatches++;
			$display("CHECK FAILED: inst_ready 0x%h with 0x%h in flight", inst_ready, sent - retired);
		end
		if (ret_valid && ret_ready) begin
			check_retire();
		end
		if (inst_valid && inst_ready) begin
			apply_model(inst_pc, inst_data);
			sent++;
		end
		stall = (inst_valid && !inst_ready) ? stall + 1 : 0;
		if (!inst_valid || inst_ready) begin
			if (sent < NUM_INSTS && r[3:2] != 2'b00) begin
				inst_valid <= 1'b1;
				inst_pc    <= next_pc;
				inst_data  <= random_inst();
				next_pc    = next_pc + 16'd2;
			end else begin
				inst_valid <= 1'b0;
			end
		end
		// alternating phases of mostly ready and mostly stalled output.
		ret_ready <= cycles[6] ? (r[1:0] == 2'b00) : (r[1:0] != 2'b00);
		cycles++;
	endtask

	initial begin
		seed = 32'h706c_f5e8;
		clk = 1'b0;
		rst = 1'b1;
		inst_valid = 1'b0;
		inst_pc = '0;
		inst_data = '0;
		ret_ready = 1'b0;
		mismatches = 0;
		protocol_errs = 0;
		timeouts = 0;
		sent = 0;
		retired = 0;
		cycles = 0;
		stall = 0;
		next_pc = 16'h3000;
		model_cc = 3'b010;
		for (int i = 0; i < 8; i++) begin
			model_regs[i] = '0;
		end
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
		compare_field("ret_valid", ret_valid, 1'b0);
		compare_field("inst_ready", inst_ready, 1'b1);
		while (sent < NUM_INSTS && stall <= STALL_LIMIT && cycles < RUN_LIMIT) begin
			step_cycle();
		end
		if (sent < NUM_INSTS) begin
			timeouts++;
			$display("timeout: input stalled after %0d of %0d instructions", sent, NUM_INSTS);
		end else begin
			waited = 0;
			while (retired < NUM_INSTS && waited < DRAIN_LIMIT) begin
				step_cycle();
				waited++;
			end
			if (retired < NUM_INSTS) begin
				timeouts++;
				$display("timeout: only %0d of %0d instructions retired", retired, NUM_INSTS);
			end else begin
				repeat (10) step_cycle();
			end
		end
		$display("errors: %0d mismatches, %0d protocol, %0d timeouts, %0d assertions",
			mismatches, protocol_errs, timeouts, dut.chk.assert_fails);
		if (mismatches == 0 && protocol_errs == 0 && timeouts == 0
			&& dut.chk.assert_fails == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== lc3b_params.svh ====
`ifndef LC3B_PARAMS_SVH
`define LC3B_PARAMS_SVH

// instruction queue entries between the input port and decode.
`define IN_FIFO_DEPTH 4

// retire queue entries between execute and the output port.
`define RET_FIFO_DEPTH 4

// architectural general purpose registers R0 to R7.
`define NUM_REGS 8

`endif

// ==== lc3b_types_pkg.sv ====
`default_nettype none

package lc3b_types_pkg;

	typedef logic [15:0] lc3b_word;
	typedef logic [2:0]  lc3b_reg;

	// condition code bits are ordered n, z, p from msb to lsb.
	typedef logic [2:0]  lc3b_cc;

	typedef enum logic [3:0] {
		op_br   = 4'b0000,
		op_add  = 4'b0001,
		op_ldb  = 4'b0010,
		op_stb  = 4'b0011,
		op_jsr  = 4'b0100,
		op_and  = 4'b0101,
		op_ldr  = 4'b0110,
		op_str  = 4'b0111,
		op_rti  = 4'b1000,
		op_not  = 4'b1001,
		op_ldi  = 4'b1010,
		op_sti  = 4'b1011,
		op_jmp  = 4'b1100,
		op_shf  = 4'b1101,
		op_lea  = 4'b1110,
		op_trap = 4'b1111
	} lc3b_opcode;

	// alu_pass forwards operand a untouched.
	typedef enum logic [1:0] {
		alu_add,
		alu_and,
		alu_not,
		alu_pass
	} lc3b_aluop;

endpackage

`default_nettype wire

// ==== pipe_pkg.sv ====
`default_nettype none

package pipe_pkg;

	import lc3b_types_pkg::*;

	// one fetched instruction with the address it came from.
	typedef struct packed {
		lc3b_word pc;
		lc3b_word inst;
	} inst_entry;

	// one retired instruction as seen at the output port.
	// cc is the code after the instruction, whether it changed it or not.
	typedef struct packed {
		lc3b_word pc;
		lc3b_reg  dest;
		lc3b_word value;
		logic     wrote;
		lc3b_cc   cc;
	} retire_entry;

endpackage

`default_nettype wire

// ==== regfile.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "lc3b_params.svh"

module regfile import lc3b_types_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  logic     load,
	input  lc3b_reg  dest,
	input  lc3b_word in_value,
	input  lc3b_reg  src_a,
	input  lc3b_reg  src_b,
	output lc3b_word reg_a,
	output lc3b_word reg_b
);

	lc3b_word regs [`NUM_REGS];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (load) begin
			regs[dest] <= in_value;
		end
	end

	// reads see the value before this cycle's write.
	assign reg_a = regs[src_a];
	assign reg_b = regs[src_b];

endmodule

`default_nettype wire

// ==== stream_fifo.sv ====
`timescale 1ns/10ps
`default_nettype none

module stream_fifo #(
	parameter type payload_t = logic [31:0],
	parameter int  DEPTH = 4
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     in_valid,
	output logic     in_ready,
	input  payload_t in_data,
	output logic     out_valid,
	input  logic     out_ready,
	output payload_t out_data
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	payload_t mem [DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             push;
	logic             pop;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign in_ready  = (count != CNT_W'(DEPTH));
	assign out_valid = (count != '0);
	assign push      = in_valid && in_ready;
	assign pop       = out_valid && out_ready;
	assign out_data  = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= in_data;
		end
	end

	// a push and a pop in the same cycle leave the count as it is.
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			if (push && !pop) begin
				count <= count + 1'b1;
			end else if (pop && !push) begin
				count <= count - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire
